/* filelist.f */
logic/rca_pkg.sv
logic/rca_cfg_decoder.sv
logic/rca_config_regs.sv
logic/rca_io_units.sv
logic/rca_grid_xbar.sv
logic/rca_subsys.sv
test/rca_subsys_properties.sv
test/rca_subsys_tb.sv

/* logic/rca_cfg_decoder.sv */
`timescale 1ns/1ps

module rca_cfg_decoder #(
    parameter int NUM_RCAS = 4,
    localparam int RCA_W = $clog2(NUM_RCAS)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cfg_valid,
    input  rca_pkg::cfg_op_t               cfg_op,
    input  logic [RCA_W-1:0]               cfg_rca,
    input  logic                           cfg_fb,
    input  logic [rca_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [rca_pkg::XLEN-1:0]       cfg_data,
    output logic                           src_wr_en,
    output logic                           dest_wr_en,
    output logic                           grid_wr_en,
    output logic                           io_mux_wr_en,
    output logic                           result_wr_en,
    output logic                           inp_map_wr_en,
    output logic                           const_wr_en,
    output logic                           wr_fb,
    output logic [RCA_W-1:0]               wr_rca,
    output logic [rca_pkg::CFG_ADDR_W-1:0] wr_addr,
    output logic [rca_pkg::XLEN-1:0]       wr_data,
    output logic                           cfg_error
);
    import rca_pkg::*;

    logic    cmd_valid;
    cfg_op_t cmd_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= cfg_valid;
        end
    end

    // Command fields are only captured with the strobe
    always_ff @(posedge clk) begin
        if (cfg_valid) begin
            cmd_op  <= cfg_op;
            wr_fb   <= cfg_fb;
            wr_rca  <= cfg_rca;
            wr_addr <= cfg_addr;
            wr_data <= cfg_data;
        end
    end

    // One enable per legal command, error pulse otherwise
    always_comb begin
        src_wr_en     = 1'b0;
        dest_wr_en    = 1'b0;
        grid_wr_en    = 1'b0;
        io_mux_wr_en  = 1'b0;
        result_wr_en  = 1'b0;
        inp_map_wr_en = 1'b0;
        const_wr_en   = 1'b0;
        cfg_error     = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                CFG_SRC_REG: begin
                    // Source registers exist only for the feedback set
                    if (wr_fb) begin
                        src_wr_en = 1'b1;
                    end else begin
                        cfg_error = 1'b1;
                    end
                end
                CFG_DEST_REG:   dest_wr_en    = 1'b1;
                CFG_GRID_MUX:   grid_wr_en    = 1'b1;
                CFG_IO_MUX:     io_mux_wr_en  = 1'b1;
                CFG_RESULT_MUX: result_wr_en  = 1'b1;
                CFG_INP_MAP:    inp_map_wr_en = 1'b1;
                CFG_CONSTANT:   const_wr_en   = 1'b1;
                CFG_NOP:        cfg_error     = 1'b1;
            endcase
        end
    end

endmodule

/* logic/rca_config_regs.sv */
`timescale 1ns/1ps

module rca_config_regs #(
    parameter int NUM_RCAS = 4,
    parameter int NUM_READ_PORTS = 2,
    parameter int NUM_WRITE_PORTS = 2,
    parameter int NUM_IO_UNITS = 4,
    parameter int NUM_GRID_INPUTS = 8,
    localparam int RCA_W = $clog2(NUM_RCAS),
    localparam int RES_W = $clog2(NUM_IO_UNITS + 1),
    localparam int IO_SEL_W = $clog2(NUM_READ_PORTS + 1),
    localparam int GRID_SEL_W = $clog2(NUM_IO_UNITS + 1)
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       src_wr_en,
    input  logic                                       dest_wr_en,
    input  logic                                       grid_wr_en,
    input  logic                                       io_mux_wr_en,
    input  logic                                       result_wr_en,
    input  logic                                       inp_map_wr_en,
    input  logic                                       const_wr_en,
    input  logic                                       wr_fb,
    input  logic [RCA_W-1:0]                           wr_rca,
    input  logic [rca_pkg::CFG_ADDR_W-1:0]             wr_addr,
    input  logic [rca_pkg::XLEN-1:0]                   wr_data,
    input  logic [RCA_W-1:0]                           rca_sel_decode,
    input  logic                                       use_fb,
    input  logic [RCA_W-1:0]                           rca_sel_wb,
    input  logic [RCA_W-1:0]                           rca_sel_issue,
    output logic [NUM_READ_PORTS-1:0][4:0]             src_reg_addrs,
    output logic [NUM_WRITE_PORTS-1:0][4:0]            dest_reg_addrs,
    output logic [NUM_WRITE_PORTS-1:0][RES_W-1:0]      fb_result_sels,
    output logic [NUM_WRITE_PORTS-1:0][RES_W-1:0]      nfb_result_sels,
    output logic [NUM_IO_UNITS-1:0]                    inp_map,
    output logic [NUM_IO_UNITS-1:0][IO_SEL_W-1:0]      io_mux_sels,
    output logic [NUM_GRID_INPUTS-1:0][GRID_SEL_W-1:0] grid_mux_sels,
    output logic [NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0] input_constants
);
    import rca_pkg::*;

    // Result selection value for a write port that takes no result
    localparam logic [RES_W-1:0] UNUSED_SEL = RES_W'(NUM_IO_UNITS);

    // Per-accelerator tables
    logic [NUM_READ_PORTS-1:0][4:0]        src_tab      [NUM_RCAS];
    logic [NUM_WRITE_PORTS-1:0][4:0]       dest_fb_tab  [NUM_RCAS];
    logic [NUM_WRITE_PORTS-1:0][4:0]       dest_nfb_tab [NUM_RCAS];
    logic [NUM_WRITE_PORTS-1:0][RES_W-1:0] res_fb_tab   [NUM_RCAS];
    logic [NUM_WRITE_PORTS-1:0][RES_W-1:0] res_nfb_tab  [NUM_RCAS];
    logic [NUM_IO_UNITS-1:0]               inp_map_tab  [NUM_RCAS];

    // CPU register numbers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_RCAS; r++) begin
                src_tab[r]      <= '0;
                dest_fb_tab[r]  <= '0;
                dest_nfb_tab[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                if (src_wr_en && wr_addr == CFG_ADDR_W'(p)) begin
                    src_tab[wr_rca][p] <= wr_data[4:0];
                end
            end
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                if (dest_wr_en && wr_addr == CFG_ADDR_W'(p)) begin
                    if (wr_fb) begin
                        dest_fb_tab[wr_rca][p] <= wr_data[4:0];
                    end else begin
                        dest_nfb_tab[wr_rca][p] <= wr_data[4:0];
                    end
                end
            end
        end
    end

    // Result crossbar selections and input valid maps
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_RCAS; r++) begin
                res_fb_tab[r]  <= {NUM_WRITE_PORTS{UNUSED_SEL}};
                res_nfb_tab[r] <= {NUM_WRITE_PORTS{UNUSED_SEL}};
                inp_map_tab[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                if (result_wr_en && wr_addr == CFG_ADDR_W'(p)) begin
                    if (wr_fb) begin
                        res_fb_tab[wr_rca][p] <= wr_data[RES_W-1:0];
                    end else begin
                        res_nfb_tab[wr_rca][p] <= wr_data[RES_W-1:0];
                    end
                end
            end
            if (inp_map_wr_en) begin
                inp_map_tab[wr_rca] <= wr_data[NUM_IO_UNITS-1:0];
            end
        end
    end

    // Global tables shared by all accelerators
    always_ff @(posedge clk) begin
        if (rst) begin
            io_mux_sels     <= '0;
            grid_mux_sels   <= '0;
            input_constants <= '0;
        end else begin
            for (int u = 0; u < NUM_IO_UNITS; u++) begin
                if (wr_addr == CFG_ADDR_W'(u)) begin
                    if (io_mux_wr_en) begin
                        io_mux_sels[u] <= wr_data[IO_SEL_W-1:0];
                    end
                    if (const_wr_en) begin
                        input_constants[u] <= wr_data;
                    end
                end
            end
            for (int g = 0; g < NUM_GRID_INPUTS; g++) begin
                if (grid_wr_en && wr_addr == CFG_ADDR_W'(g)) begin
                    grid_mux_sels[g] <= wr_data[GRID_SEL_W-1:0];
                end
            end
        end
    end

    // Decode read with no source registers for non-feedback instructions
    always_comb begin
        if (use_fb) begin
            src_reg_addrs  = src_tab[rca_sel_decode];
            dest_reg_addrs = dest_fb_tab[rca_sel_decode];
        end else begin
            src_reg_addrs  = '0;
            dest_reg_addrs = dest_nfb_tab[rca_sel_decode];
        end
    end

    // Write-back and issue reads
    assign fb_result_sels  = res_fb_tab[rca_sel_wb];
    assign nfb_result_sels = res_nfb_tab[rca_sel_wb];
    assign inp_map         = inp_map_tab[rca_sel_issue];

endmodule

/* logic/rca_grid_xbar.sv */
`timescale 1ns/1ps

module rca_grid_xbar #(
    parameter int NUM_IO_UNITS = 4,
    parameter int NUM_GRID_INPUTS = 8,
    localparam int GRID_SEL_W = $clog2(NUM_IO_UNITS + 1)
) (
    input  logic [NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0]    io_values,
    input  logic [NUM_GRID_INPUTS-1:0][GRID_SEL_W-1:0]    grid_mux_sels,
    output logic [NUM_GRID_INPUTS-1:0][rca_pkg::XLEN-1:0] grid_values
);

    // Selections with no matching unit leave the grid input at zero
    always_comb begin
        for (int g = 0; g < NUM_GRID_INPUTS; g++) begin
            grid_values[g] = '0;
            for (int u = 0; u < NUM_IO_UNITS; u++) begin
                if (grid_mux_sels[g] == GRID_SEL_W'(u)) begin
                    grid_values[g] = io_values[u];
                end
            end
        end
    end

endmodule

/* logic/rca_io_units.sv */
`timescale 1ns/1ps

module rca_io_units #(
    parameter int NUM_READ_PORTS = 2,
    parameter int NUM_IO_UNITS = 4,
    localparam int IO_SEL_W = $clog2(NUM_READ_PORTS + 1)
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         operand_valid,
    input  logic [NUM_READ_PORTS-1:0][rca_pkg::XLEN-1:0] cpu_operands,
    input  logic [NUM_IO_UNITS-1:0][IO_SEL_W-1:0]        io_mux_sels,
    input  logic [NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0]   input_constants,
    input  logic [NUM_IO_UNITS-1:0]                      inp_map,
    output logic [NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0]   io_values,
    output logic [NUM_IO_UNITS-1:0]                      io_valid
);
    import rca_pkg::*;

    logic [NUM_IO_UNITS-1:0][XLEN-1:0] unit_in;

    // Any selection past the last read port picks the unit's constant
    always_comb begin
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            unit_in[u] = input_constants[u];
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                if (io_mux_sels[u] == IO_SEL_W'(p)) begin
                    unit_in[u] = cpu_operands[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (operand_valid) begin
            io_values <= unit_in;
        end
    end

    // One-cycle valid bits for the units mapped to the issuing RCA
    always_ff @(posedge clk) begin
        if (rst) begin
            io_valid <= '0;
        end else if (operand_valid) begin
            io_valid <= inp_map;
        end else begin
            io_valid <= '0;
        end
    end

endmodule

/* logic/rca_pkg.sv */
package rca_pkg;

    // Operand and input constant width
    localparam int XLEN = 32;

    // Command address field wide enough for the largest table index
    localparam int CFG_ADDR_W = 3;

    // Configuration command opcodes
    typedef enum logic [2:0] {
        CFG_SRC_REG    = 3'd0,
        CFG_DEST_REG   = 3'd1,
        CFG_GRID_MUX   = 3'd2,
        CFG_IO_MUX     = 3'd3,
        CFG_RESULT_MUX = 3'd4,
        CFG_INP_MAP    = 3'd5,
        CFG_CONSTANT   = 3'd6,
        CFG_NOP        = 3'd7
    } cfg_op_t;

endpackage

/* logic/rca_subsys.sv */
`timescale 1ns/1ps

module rca_subsys #(
    parameter int NUM_RCAS = 4,
    parameter int NUM_READ_PORTS = 2,
    parameter int NUM_WRITE_PORTS = 2,
    parameter int NUM_IO_UNITS = 4,
    parameter int NUM_GRID_INPUTS = 8,
    localparam int RCA_W = $clog2(NUM_RCAS),
    localparam int RES_W = $clog2(NUM_IO_UNITS + 1)
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          cfg_valid,
    input  rca_pkg::cfg_op_t                              cfg_op,
    input  logic [RCA_W-1:0]                              cfg_rca,
    input  logic                                          cfg_fb,
    input  logic [rca_pkg::CFG_ADDR_W-1:0]                cfg_addr,
    input  logic [rca_pkg::XLEN-1:0]                      cfg_data,
    input  logic [RCA_W-1:0]                              rca_sel_decode,
    input  logic                                          use_fb,
    input  logic [RCA_W-1:0]                              rca_sel_wb,
    input  logic [RCA_W-1:0]                              rca_sel_issue,
    input  logic                                          operand_valid,
    input  logic [NUM_READ_PORTS-1:0][rca_pkg::XLEN-1:0]  cpu_operands,
    output logic                                          cfg_error,
    output logic [NUM_READ_PORTS-1:0][4:0]                src_reg_addrs,
    output logic [NUM_WRITE_PORTS-1:0][4:0]               dest_reg_addrs,
    output logic [NUM_WRITE_PORTS-1:0][RES_W-1:0]         fb_result_sels,
    output logic [NUM_WRITE_PORTS-1:0][RES_W-1:0]         nfb_result_sels,
    output logic [NUM_GRID_INPUTS-1:0][rca_pkg::XLEN-1:0] grid_values,
    output logic [NUM_IO_UNITS-1:0]                       io_valid
);
    import rca_pkg::*;

    localparam int IO_SEL_W = $clog2(NUM_READ_PORTS + 1);
    localparam int GRID_SEL_W = $clog2(NUM_IO_UNITS + 1);

    // Registered command toward the tables
    logic                  src_wr_en;
    logic                  dest_wr_en;
    logic                  grid_wr_en;
    logic                  io_mux_wr_en;
    logic                  result_wr_en;
    logic                  inp_map_wr_en;
    logic                  const_wr_en;
    logic                  wr_fb;
    logic [RCA_W-1:0]      wr_rca;
    logic [CFG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    // Operand routing configuration and data
    logic [NUM_IO_UNITS-1:0]                    inp_map;
    logic [NUM_IO_UNITS-1:0][IO_SEL_W-1:0]      io_mux_sels;
    logic [NUM_GRID_INPUTS-1:0][GRID_SEL_W-1:0] grid_mux_sels;
    logic [NUM_IO_UNITS-1:0][XLEN-1:0]          input_constants;
    logic [NUM_IO_UNITS-1:0][XLEN-1:0]          io_values;

    rca_cfg_decoder #(
        .NUM_RCAS(NUM_RCAS)
    ) u_decoder (
        .clk(clk), .rst(rst),
        .cfg_valid(cfg_valid), .cfg_op(cfg_op), .cfg_rca(cfg_rca),
        .cfg_fb(cfg_fb), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .src_wr_en(src_wr_en), .dest_wr_en(dest_wr_en), .grid_wr_en(grid_wr_en),
        .io_mux_wr_en(io_mux_wr_en), .result_wr_en(result_wr_en),
        .inp_map_wr_en(inp_map_wr_en), .const_wr_en(const_wr_en),
        .wr_fb(wr_fb), .wr_rca(wr_rca), .wr_addr(wr_addr), .wr_data(wr_data),
        .cfg_error(cfg_error)
    );

    rca_config_regs #(
        .NUM_RCAS(NUM_RCAS), .NUM_READ_PORTS(NUM_READ_PORTS),
        .NUM_WRITE_PORTS(NUM_WRITE_PORTS), .NUM_IO_UNITS(NUM_IO_UNITS),
        .NUM_GRID_INPUTS(NUM_GRID_INPUTS)
    ) u_regs (
        .clk(clk), .rst(rst),
        .src_wr_en(src_wr_en), .dest_wr_en(dest_wr_en), .grid_wr_en(grid_wr_en),
        .io_mux_wr_en(io_mux_wr_en), .result_wr_en(result_wr_en),
        .inp_map_wr_en(inp_map_wr_en), .const_wr_en(const_wr_en),
        .wr_fb(wr_fb), .wr_rca(wr_rca), .wr_addr(wr_addr), .wr_data(wr_data),
        .rca_sel_decode(rca_sel_decode), .use_fb(use_fb),
        .rca_sel_wb(rca_sel_wb), .rca_sel_issue(rca_sel_issue),
        .src_reg_addrs(src_reg_addrs), .dest_reg_addrs(dest_reg_addrs),
        .fb_result_sels(fb_result_sels), .nfb_result_sels(nfb_result_sels),
        .inp_map(inp_map), .io_mux_sels(io_mux_sels),
        .grid_mux_sels(grid_mux_sels), .input_constants(input_constants)
    );

    rca_io_units #(
        .NUM_READ_PORTS(NUM_READ_PORTS), .NUM_IO_UNITS(NUM_IO_UNITS)
    ) u_io (
        .clk(clk), .rst(rst),
        .operand_valid(operand_valid), .cpu_operands(cpu_operands),
        .io_mux_sels(io_mux_sels), .input_constants(input_constants),
        .inp_map(inp_map), .io_values(io_values), .io_valid(io_valid)
    );

    rca_grid_xbar #(
        .NUM_IO_UNITS(NUM_IO_UNITS), .NUM_GRID_INPUTS(NUM_GRID_INPUTS)
    ) u_xbar (
        .io_values(io_values), .grid_mux_sels(grid_mux_sels),
        .grid_values(grid_values)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench; exit status reports pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rca_subsys_tb \
    -f filelist.f -o rca_sim \
    && ./obj_dir/rca_sim \
    || exit 1

/* test/rca_subsys_properties.sv */
`timescale 1ns/1ps

module rca_subsys_properties (
    input logic clk,
    input logic rst,
    input logic cfg_valid,
    input logic src_wr_en,
    input logic dest_wr_en,
    input logic grid_wr_en,
    input logic io_mux_wr_en,
    input logic result_wr_en,
    input logic inp_map_wr_en,
    input logic const_wr_en,
    input logic cfg_error
);

    logic [6:0] wr_ens;

    assign wr_ens = {src_wr_en, dest_wr_en, grid_wr_en, io_mux_wr_en,
                     result_wr_en, inp_map_wr_en, const_wr_en};

    single_enable: assert property (@(posedge clk) disable iff (rst)
        $onehot0(wr_ens))
    else $error("more than one write enable high");

    error_excludes_enable: assert property (@(posedge clk) disable iff (rst)
        cfg_error |-> wr_ens == '0)
    else $error("write enable high together with cfg_error");

    // Outputs quiet once an idle input has passed through the command register
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !cfg_valid |=> (wr_ens == '0 && !cfg_error))
    else $error("decoder output active after an idle cycle");

endmodule

bind rca_cfg_decoder rca_subsys_properties u_props (
    .clk(clk), .rst(rst), .cfg_valid(cfg_valid),
    .src_wr_en(src_wr_en), .dest_wr_en(dest_wr_en), .grid_wr_en(grid_wr_en),
    .io_mux_wr_en(io_mux_wr_en), .result_wr_en(result_wr_en),
    .inp_map_wr_en(inp_map_wr_en), .const_wr_en(const_wr_en),
    .cfg_error(cfg_error)
);

/* test/rca_subsys_tb.sv */
`timescale 1ns/1ps

module rca_subsys_tb;
    import rca_pkg::*;

    localparam int NUM_RCAS = 4;
    localparam int NUM_READ_PORTS = 2;
    localparam int NUM_WRITE_PORTS = 2;
    localparam int NUM_IO_UNITS = 4;
    localparam int NUM_GRID_INPUTS = 8;
    localparam int RCA_W = $clog2(NUM_RCAS);
    localparam int RES_W = $clog2(NUM_IO_UNITS + 1);
    localparam int IO_SEL_W = $clog2(NUM_READ_PORTS + 1);
    localparam int GRID_SEL_W = $clog2(NUM_IO_UNITS + 1);

    logic                                  clk;
    logic                                  rst;
    logic                                  cfg_valid;
    cfg_op_t                               cfg_op;
    logic [RCA_W-1:0]                      cfg_rca;
    logic                                  cfg_fb;
    logic [CFG_ADDR_W-1:0]                 cfg_addr;
    logic [XLEN-1:0]                       cfg_data;
    logic [RCA_W-1:0]                      rca_sel_decode;
    logic                                  use_fb;
    logic [RCA_W-1:0]                      rca_sel_wb;
    logic [RCA_W-1:0]                      rca_sel_issue;
    logic                                  operand_valid;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]   cpu_operands;
    logic                                  cfg_error;
    logic [NUM_READ_PORTS-1:0][4:0]        src_reg_addrs;
    logic [NUM_WRITE_PORTS-1:0][4:0]       dest_reg_addrs;
    logic [NUM_WRITE_PORTS-1:0][RES_W-1:0] fb_result_sels;
    logic [NUM_WRITE_PORTS-1:0][RES_W-1:0] nfb_result_sels;
    logic [NUM_GRID_INPUTS-1:0][XLEN-1:0]  grid_values;
    logic [NUM_IO_UNITS-1:0]               io_valid;

    // Shadow copies of the configuration tables
    logic [4:0]              src_sh      [NUM_RCAS][NUM_READ_PORTS];
    logic [4:0]              dest_fb_sh  [NUM_RCAS][NUM_WRITE_PORTS];
    logic [4:0]              dest_nfb_sh [NUM_RCAS][NUM_WRITE_PORTS];
    logic [RES_W-1:0]        res_fb_sh   [NUM_RCAS][NUM_WRITE_PORTS];
    logic [RES_W-1:0]        res_nfb_sh  [NUM_RCAS][NUM_WRITE_PORTS];
    logic [NUM_IO_UNITS-1:0] map_sh      [NUM_RCAS];
    logic [IO_SEL_W-1:0]     io_sel_sh   [NUM_IO_UNITS];
    logic [GRID_SEL_W-1:0]   grid_sel_sh [NUM_GRID_INPUTS];
    logic [XLEN-1:0]         const_sh    [NUM_IO_UNITS];
    logic [31:0]             rng;

    rca_subsys #(
        .NUM_RCAS(NUM_RCAS), .NUM_READ_PORTS(NUM_READ_PORTS),
        .NUM_WRITE_PORTS(NUM_WRITE_PORTS), .NUM_IO_UNITS(NUM_IO_UNITS),
        .NUM_GRID_INPUTS(NUM_GRID_INPUTS)
    ) dut0 (
        .clk(clk), .rst(rst),
        .cfg_valid(cfg_valid), .cfg_op(cfg_op), .cfg_rca(cfg_rca),
        .cfg_fb(cfg_fb), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .rca_sel_decode(rca_sel_decode), .use_fb(use_fb),
        .rca_sel_wb(rca_sel_wb), .rca_sel_issue(rca_sel_issue),
        .operand_valid(operand_valid), .cpu_operands(cpu_operands),
        .cfg_error(cfg_error), .src_reg_addrs(src_reg_addrs),
        .dest_reg_addrs(dest_reg_addrs), .fb_result_sels(fb_result_sels),
        .nfb_result_sels(nfb_result_sels), .grid_values(grid_values),
        .io_valid(io_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic is_illegal(input cfg_op_t op, input logic fb);
        return (op == CFG_NOP) || (op == CFG_SRC_REG && !fb);
    endfunction

    // Outputs stay quiet unless an operand strobe came one cycle earlier
    io_valid_quiet: assert property (@(posedge clk) disable iff (rst)
        !$past(operand_valid) |-> io_valid == '0)
    else begin
        $display("io_valid was high without an operand strobe");
        stop_run();
    end

    error_follows_illegal: assert property (@(posedge clk) disable iff (rst)
        cfg_valid && is_illegal(cfg_op, cfg_fb) |=> cfg_error)
    else begin
        $display("an illegal command did not raise cfg_error");
        stop_run();
    end

    no_error_on_legal: assert property (@(posedge clk) disable iff (rst)
        cfg_valid && !is_illegal(cfg_op, cfg_fb) |=> !cfg_error)
    else begin
        $display("a legal command raised cfg_error");
        stop_run();
    end

    task automatic expect_equal(input string name, input logic [31:0] expv,
                                input logic [31:0] act);
        assert (expv === act) else begin
            $display("FAILED %s expected %h actual %h", name, expv, act);
            stop_run();
        end
    endtask

    task automatic reset_shadow();
        for (int r = 0; r < NUM_RCAS; r++) begin
            map_sh[r] = '0;
            for (int p = 0; p < NUM_READ_PORTS; p++) src_sh[r][p] = '0;
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                dest_fb_sh[r][p]  = '0;
                dest_nfb_sh[r][p] = '0;
                res_fb_sh[r][p]   = RES_W'(NUM_IO_UNITS);
                res_nfb_sh[r][p]  = RES_W'(NUM_IO_UNITS);
            end
        end
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            io_sel_sh[u] = '0;
            const_sh[u]  = '0;
        end
        for (int g = 0; g < NUM_GRID_INPUTS; g++) grid_sel_sh[g] = '0;
    endtask

    // Shadow table updates that illegal commands skip
    function automatic void apply_cmd(input cfg_op_t op, input int rca, input logic fb,
                                      input int addr, input logic [XLEN-1:0] data);
        case (op)
            CFG_SRC_REG: if (fb && addr < NUM_READ_PORTS) src_sh[rca][addr] = data[4:0];
            CFG_DEST_REG: begin
                if (addr < NUM_WRITE_PORTS && fb) dest_fb_sh[rca][addr] = data[4:0];
                if (addr < NUM_WRITE_PORTS && !fb) dest_nfb_sh[rca][addr] = data[4:0];
            end
            CFG_RESULT_MUX: begin
                if (addr < NUM_WRITE_PORTS && fb) res_fb_sh[rca][addr] = data[RES_W-1:0];
                if (addr < NUM_WRITE_PORTS && !fb) res_nfb_sh[rca][addr] = data[RES_W-1:0];
            end
            CFG_GRID_MUX: if (addr < NUM_GRID_INPUTS) grid_sel_sh[addr] = data[GRID_SEL_W-1:0];
            CFG_IO_MUX: if (addr < NUM_IO_UNITS) io_sel_sh[addr] = data[IO_SEL_W-1:0];
            CFG_CONSTANT: if (addr < NUM_IO_UNITS) const_sh[addr] = data;
            CFG_INP_MAP: map_sh[rca] = data[NUM_IO_UNITS-1:0];
            default: ;
        endcase
    endfunction

    // Strobe one command on the next cycle and leave cfg_valid high
    task automatic drive_cmd(input cfg_op_t op, input int rca, input logic fb,
                             input int addr, input logic [XLEN-1:0] data);
        @(posedge clk);
        #1;
        cfg_valid = 1'b1;
        cfg_op    = op;
        cfg_rca   = RCA_W'(rca);
        cfg_fb    = fb;
        cfg_addr  = CFG_ADDR_W'(addr);
        cfg_data  = data;
        apply_cmd(op, rca, fb, addr, data);
    endtask

    // Drop the strobe and wait for the last write edge
    task automatic close_cmds();
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic expect_error_pulse(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
        while (!cfg_error && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (cfg_error) else begin
            $display("cfg_error never pulsed after the %s command", name);
            stop_run();
        end
        @(posedge clk);
        #1;
        expect_equal({name, " pulse end"}, 32'd0, 32'(cfg_error));
    endtask

    task automatic read_decode(input int r);
        for (int fb = 0; fb < 2; fb++) begin
            @(posedge clk);
            #1;
            rca_sel_decode = RCA_W'(r);
            use_fb = fb[0];
            #1;
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                expect_equal($sformatf("src rca%0d fb%0d port%0d", r, fb, p),
                             fb != 0 ? 32'(src_sh[r][p]) : 32'd0, 32'(src_reg_addrs[p]));
            end
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                expect_equal($sformatf("dest rca%0d fb%0d port%0d", r, fb, p),
                             fb != 0 ? 32'(dest_fb_sh[r][p]) : 32'(dest_nfb_sh[r][p]),
                             32'(dest_reg_addrs[p]));
            end
        end
    endtask

    task automatic read_wb(input int r);
        @(posedge clk);
        #1;
        rca_sel_wb = RCA_W'(r);
        #1;
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            expect_equal($sformatf("fb result rca%0d port%0d", r, p),
                         32'(res_fb_sh[r][p]), 32'(fb_result_sels[p]));
            expect_equal($sformatf("nfb result rca%0d port%0d", r, p),
                         32'(res_nfb_sh[r][p]), 32'(nfb_result_sels[p]));
        end
    endtask

    task automatic read_all_tables();
        for (int r = 0; r < NUM_RCAS; r++) begin
            read_decode(r);
            read_wb(r);
        end
    endtask

    // One operand strobe for accelerator r and a check of the routed grid values
    task automatic run_operands(input int r);
        logic [XLEN-1:0] unit_val [NUM_IO_UNITS];
        logic [XLEN-1:0] expv;
        int              sel;
        @(posedge clk);
        #1;
        rca_sel_issue   = RCA_W'(r);
        cpu_operands[0] = next_rand();
        cpu_operands[1] = next_rand();
        operand_valid   = 1'b1;
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            sel = int'(io_sel_sh[u]);
            unit_val[u] = sel < NUM_READ_PORTS ? cpu_operands[sel] : const_sh[u];
        end
        @(posedge clk);
        #1;
        operand_valid   = 1'b0;
        cpu_operands[0] = next_rand();
        cpu_operands[1] = next_rand();
        expect_equal($sformatf("io_valid rca%0d", r), 32'(map_sh[r]), 32'(io_valid));
        for (int g = 0; g < NUM_GRID_INPUTS; g++) begin
            sel  = int'(grid_sel_sh[g]);
            expv = sel < NUM_IO_UNITS ? unit_val[sel] : '0;
            expect_equal($sformatf("grid input %0d rca%0d", g, r), expv, grid_values[g]);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic        fb;
        cfg_op_t     op;
        rng            = 32'd79;
        rst            = 1'b1;
        cfg_valid      = 1'b0;
        cfg_op         = CFG_NOP;
        cfg_rca        = '0;
        cfg_fb         = 1'b0;
        cfg_addr       = '0;
        cfg_data       = '0;
        rca_sel_decode = '0;
        use_fb         = 1'b0;
        rca_sel_wb     = '0;
        rca_sel_issue  = '0;
        operand_valid  = 1'b0;
        cpu_operands   = '0;
        reset_shadow();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset values
        expect_equal("reset io_valid", 32'd0, 32'(io_valid));
        expect_equal("reset cfg_error", 32'd0, 32'(cfg_error));
        read_all_tables();

        // Source and destination register numbers
        for (int i = 0; i < 16; i++) begin
            rnd = next_rand();
            fb  = rnd[0];
            op  = (fb && rnd[1]) ? CFG_SRC_REG : CFG_DEST_REG;
            drive_cmd(op, int'(rnd[5:4]), fb, int'(rnd[8]), next_rand());
            close_cmds();
            read_decode(int'(rnd[5:4]));
        end

        // Result crossbar selections in both copies
        for (int i = 0; i < 10; i++) begin
            rnd = next_rand();
            drive_cmd(CFG_RESULT_MUX, int'(rnd[5:4]), rnd[0], int'(rnd[8]), next_rand());
            close_cmds();
            read_wb(int'(rnd[5:4]));
        end

        // Illegal commands
        drive_cmd(CFG_SRC_REG, 1, 1'b0, 0, 32'h0000_001f);
        expect_error_pulse("non-feedback source");
        read_all_tables();
        drive_cmd(CFG_NOP, 2, 1'b1, 1, next_rand());
        expect_error_pulse("no-op");
        read_all_tables();

        // Operand routing setup strobed back to back, every mux input in use
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            drive_cmd(CFG_IO_MUX, 0, 1'b0, u, XLEN'(u % (NUM_READ_PORTS + 1)));
            drive_cmd(CFG_CONSTANT, 0, 1'b0, u, next_rand());
        end
        for (int g = 0; g < NUM_GRID_INPUTS; g++) begin
            drive_cmd(CFG_GRID_MUX, 0, 1'b0, g, next_rand());
        end
        for (int r = 0; r < NUM_RCAS; r++) begin
            drive_cmd(CFG_INP_MAP, r, 1'b0, 0, next_rand());
        end
        close_cmds();
        for (int r = 0; r < NUM_RCAS; r++) begin
            run_operands(r);
        end

        // Mixed back-to-back table writes
        for (int i = 0; i < 8; i++) begin
            rnd = next_rand();
            fb  = rnd[0];
            if (fb && rnd[2]) begin
                op = CFG_SRC_REG;
            end else begin
                op = rnd[1] ? CFG_RESULT_MUX : CFG_DEST_REG;
            end
            drive_cmd(op, int'(rnd[5:4]), fb, int'(rnd[8]), next_rand());
        end
        close_cmds();
        read_all_tables();

        $display("test passed");
        $finish;
    end

endmodule
